// ==== tau_fill.f ====
source/tau_pkg.sv
source/sram_write_collector.sv
source/vector_sram.sv
source/linear_fill_unit.sv
bench/tb_clock_gen.sv
bench/linear_fill_unit_assert.sv
bench/linear_fill_unit_tb.sv

// ==== Makefile ====
# Lint, simulate and clean the linear fill unit with Verilator

VERILATOR ?= verilator
TOP ?= linear_fill_unit_tb
FLIST ?= tau_fill.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# The run passes only when the testbench prints the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/linear_fill_unit_tb.sv ====
// Testbench for the linear fill unit
// Job table, DRAM line model, reference model, readback checks and watchdog
module linear_fill_unit_tb;
	import tau_pkg::*;

	localparam int LBW = 8;
	localparam int NJOBS = 3;
	localparam int NROWS = 11;
	// 200 cycles of 4 time units for every table row
	localparam int WATCHDOG = NROWS * 200 * 4;

	typedef struct packed {
		logic [7:0] start;
		logic [8:0] size;
		logic [1:0] id;
		logic [15:0] padv;
		logic [3:0] first;
		logic [3:0] nrows;
	} job_t;

	typedef struct packed {
		cmd_t cmd;
		logic [7:0] line;
	} row_t;

	// ====================
	// Stimulus table
	// ====================
	localparam job_t JOBS [NJOBS] = '{
		'{8'h10, 9'd16, 2'd1, 16'hdead, 4'd0, 4'd3},
		'{8'h40, 9'd16, 2'd2, 16'hbeef, 4'd3, 4'd4},
		'{8'h20, 9'd24, 2'd3, 16'h0f0f, 4'd7, 4'd4}
	};

	localparam row_t ROWS [NROWS] = '{
		// Line 3 serves two copies, the second crosses a vector boundary
		'{'{CMD_COPY, 1'b0, 3'd2, 4'd5}, 8'd3},
		'{'{CMD_COPY, 1'b1, 3'd0, 4'd6}, 8'd3},
		'{'{CMD_COPY, 1'b1, 3'd1, 4'd5}, 8'd4},
		// Pad with no line offered, then line 7 shared by three commands
		// The broadcast run crosses a vector boundary
		'{'{CMD_PAD, 1'b0, 3'd0, 4'd4}, 8'd0},
		'{'{CMD_BCAST, 1'b0, 3'd6, 4'd5}, 8'd7},
		'{'{CMD_PAD, 1'b0, 3'd0, 4'd3}, 8'd7},
		'{'{CMD_COPY, 1'b1, 3'd4, 4'd4}, 8'd7},
		// Region right after the first one
		'{'{CMD_COPY, 1'b1, 3'd0, 4'd8}, 8'd9},
		'{'{CMD_BCAST, 1'b1, 3'd2, 4'd8}, 8'd10},
		'{'{CMD_PAD, 1'b0, 3'd0, 4'd2}, 8'd0},
		'{'{CMD_PAD, 1'b1, 3'd0, 4'd6}, 8'd11}
	};

	string job_names [NJOBS] = '{"copy_span", "bcast_pad", "second_job"};

	logic clk;
	logic rst;
	logic alloc_rdy;
	logic alloc_ack;
	logic [LBW-1:0] linear;
	logic [LBW:0] size;
	alloc_t alloc;
	logic cmd_rdy;
	logic cmd_ack;
	cmd_t cmd;
	logic dramrd_rdy;
	logic dramrd_ack;
	line_t dramrd;
	logic done_rdy;
	logic done_ack;
	logic [LBW-1:0] done_linear;
	logic [ID_BW-1:0] done_id;
	logic [LBW-CV_BW-1:0] rd_addr;
	vector_t rd_data;

	logic [31:0] lfsr = 32'h9e4e;
	logic [DBW-1:0] shadow [256];
	int checks = 0;
	int errors = 0;

	tb_clock_gen clk_gen_i (
		.o_clk (clk),
		.o_rst (rst)
	);

	linear_fill_unit #(
		.LBW(LBW)
	) dut_i (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_alloc_rdy   (alloc_rdy),
		.o_alloc_ack   (alloc_ack),
		.i_linear      (linear),
		.i_size        (size),
		.i_alloc       (alloc),
		.i_cmd_rdy     (cmd_rdy),
		.o_cmd_ack     (cmd_ack),
		.i_cmd         (cmd),
		.i_dramrd_rdy  (dramrd_rdy),
		.o_dramrd_ack  (dramrd_ack),
		.i_dramrd      (dramrd),
		.o_done_rdy    (done_rdy),
		.i_done_ack    (done_ack),
		.o_done_linear (done_linear),
		.o_done_id     (done_id),
		.i_rd_addr     (rd_addr),
		.o_rd_data     (rd_data)
	);

	// ====================
	// Models
	// ====================
	// Galois LFSR, one step per bit taken
	function automatic logic next_rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	// DRAM line contents as a fixed function of the line number
	function automatic line_t make_line(input logic [7:0] n);
		line_t l;
		for (int w = 0; w < CSIZE; w++) begin
			l[w] = 16'(n) * 16'h0123 + 16'(w) * 16'h1011 + 16'h4000;
		end
		return l;
	endfunction

	// Replays one job's commands into the shadow memory
	task automatic model_job(input int j);
		job_t jb;
		row_t rw;
		line_t ln;
		logic [7:0] addr;
		logic [2:0] idx;
		jb = JOBS[j];
		addr = jb.start;
		for (int r = int'(jb.first); r < int'(jb.first) + int'(jb.nrows); r++) begin
			rw = ROWS[r];
			ln = make_line(rw.line);
			for (int k = 0; k < int'(rw.cmd.len); k++) begin
				idx = 3'(int'(rw.cmd.addrofs) + k);
				case (rw.cmd.ctype)
					CMD_COPY: shadow[addr] = ln[idx];
					CMD_BCAST: shadow[addr] = ln[rw.cmd.addrofs];
					default: shadow[addr] = jb.padv;
				endcase
				addr = addr + 8'd1;
			end
		end
	endtask

	// ====================
	// Channel drivers
	// ====================
	task automatic random_gap();
		while (next_rand_bit()) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic apply_row(input int j, input int r);
		row_t rw;
		logic cack;
		logic dack;
		rw = ROWS[r];
		random_gap();
		cmd = rw.cmd;
		cmd_rdy = 1'b1;
		// Plain pads inside or before a line leave the line channel alone
		if (rw.cmd.islast || rw.cmd.ctype != CMD_PAD) begin
			dramrd = make_line(rw.line);
			dramrd_rdy = 1'b1;
		end
		do begin
			@(negedge clk);
			cack = cmd_ack;
			dack = dramrd_ack;
			checks++;
			assert (!dack || (cack && rw.cmd.islast)) else begin
				$display("%s row %0d: line taken before its last command", job_names[j], r);
				errors++;
			end
			@(posedge clk);
			#1;
		end while (!cack);
		checks++;
		assert (dack == rw.cmd.islast) else begin
			$display("[FAIL] %s row %0d line ack: expected %b, actual %b",
				job_names[j], r, rw.cmd.islast, dack);
			errors++;
		end
		cmd_rdy = 1'b0;
		if (dack) dramrd_rdy = 1'b0;
	endtask

	task automatic run_job(input int j);
		job_t jb;
		logic got;
		jb = JOBS[j];
		random_gap();
		linear = jb.start;
		size = jb.size;
		alloc.id = jb.id;
		alloc.padv = jb.padv;
		alloc_rdy = 1'b1;
		do begin
			@(negedge clk);
			got = alloc_ack;
			@(posedge clk);
			#1;
		end while (!got);
		alloc_rdy = 1'b0;
		for (int r = int'(jb.first); r < int'(jb.first) + int'(jb.nrows); r++) begin
			apply_row(j, r);
		end
		do begin
			@(negedge clk);
		end while (!done_rdy);
		checks += 2;
		assert (done_linear == jb.start) else begin
			$display("[FAIL] %s done address: expected %h, actual %h",
				job_names[j], jb.start, done_linear);
			errors++;
		end
		assert (done_id == jb.id) else begin
			$display("[FAIL] %s done id: expected %0d, actual %0d", job_names[j], jb.id, done_id);
			errors++;
		end
		@(posedge clk);
		#1;
		random_gap();
		done_ack = 1'b1;
		@(negedge clk);
		checks++;
		assert (done_rdy) else begin
			$display("%s: done dropped before it was acknowledged", job_names[j]);
			errors++;
		end
		@(posedge clk);
		#1;
		done_ack = 1'b0;
	endtask

	// Reads every vector of a region and compares it with the shadow
	task automatic check_region(input int j);
		job_t jb;
		vector_t want;
		logic [7:0] base;
		jb = JOBS[j];
		for (int v = 0; v < int'(jb.size) / VSIZE; v++) begin
			base = 8'(int'(jb.start) + v * VSIZE);
			rd_addr = base[LBW-1:CV_BW];
			@(posedge clk);
			@(negedge clk);
			for (int w = 0; w < VSIZE; w++) begin
				want[w] = shadow[base + 8'(w)];
			end
			checks++;
			assert (rd_data == want) else begin
				$display("[FAIL] %s vector %0d: expected %h, actual %h",
					job_names[j], v, want, rd_data);
				errors++;
			end
			@(posedge clk);
			#1;
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		alloc_rdy = 1'b0;
		linear = '0;
		size = '0;
		alloc = '0;
		cmd_rdy = 1'b0;
		cmd = '0;
		dramrd_rdy = 1'b0;
		dramrd = '0;
		done_ack = 1'b0;
		rd_addr = '0;
		wait (rst == 1'b1);
		@(posedge clk);
		#1;
		for (int j = 0; j < NJOBS; j++) begin
			model_job(j);
			run_job(j);
			check_region(j);
		end
		// Earlier regions must survive the later jobs
		for (int j = 0; j < NJOBS; j++) begin
			check_region(j);
		end
		// Property failures from the bound handshake checker
		errors += dut_i.collector_i.assert_i.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("Timeout: run did not finish within %0d time units", WATCHDOG);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== bench/linear_fill_unit_assert.sv ====
// Handshake and reset assertions for the write collector, attached by bind
module linear_fill_unit_assert (
	input logic i_clk,
	input logic i_rst,
	input logic i_alloc_rdy,
	input logic i_alloc_ack,
	input logic i_cmd_rdy,
	input logic i_cmd_ack,
	input logic i_dramrd_rdy,
	input logic i_dramrd_ack,
	input logic i_done_rdy,
	input logic i_done_ack,
	input logic i_wr_dval
);
	// Number of failed properties
	int fail_count = 0;

	// No ack without rdy
	alloc_ack_a: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_alloc_ack |-> i_alloc_rdy) else begin
		$error("alloc ack without rdy");
		fail_count++;
	end
	cmd_ack_a: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_cmd_ack |-> i_cmd_rdy) else begin
		$error("cmd ack without rdy");
		fail_count++;
	end
	dramrd_ack_a: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_dramrd_ack |-> i_dramrd_rdy) else begin
		$error("dramrd ack without rdy");
		fail_count++;
	end

	// Done stays up until the consumer takes it
	done_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_done_rdy && !i_done_ack |=> i_done_rdy) else begin
		$error("done dropped before ack");
		fail_count++;
	end

	reset_wr_a: assert property (@(posedge i_clk)
		!i_rst |-> !i_wr_dval) else begin
		$error("vector write during reset");
		fail_count++;
	end
endmodule

bind sram_write_collector linear_fill_unit_assert assert_i (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_alloc_rdy  (i_alloc_rdy),
	.i_alloc_ack  (o_alloc_ack),
	.i_cmd_rdy    (i_cmd_rdy),
	.i_cmd_ack    (o_cmd_ack),
	.i_dramrd_rdy (i_dramrd_rdy),
	.i_dramrd_ack (o_dramrd_ack),
	.i_done_rdy   (o_done_rdy),
	.i_done_ack   (i_done_ack),
	.i_wr_dval    (o_wr_dval)
);

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and active-low reset
module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);
	// Period of 4
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b0;
		repeat (8) @(posedge o_clk);
		#1;
		o_rst = 1'b1;
	end
endmodule

// ==== source/linear_fill_unit.sv ====
// Linear fill unit top level
// Write collector feeding the local vector SRAM
module linear_fill_unit #(
	parameter int LBW = 8
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	// Region allocation
	input  logic                              i_alloc_rdy,
	output logic                              o_alloc_ack,
	input  logic [LBW-1:0]                    i_linear,
	input  logic [LBW:0]                      i_size,
	input  tau_pkg::alloc_t                   i_alloc,
	// Fill commands
	input  logic                              i_cmd_rdy,
	output logic                              o_cmd_ack,
	input  tau_pkg::cmd_t                     i_cmd,
	// DRAM line data
	input  logic                              i_dramrd_rdy,
	output logic                              o_dramrd_ack,
	input  tau_pkg::line_t                    i_dramrd,
	// Region finished
	output logic                              o_done_rdy,
	input  logic                              i_done_ack,
	output logic [LBW-1:0]                    o_done_linear,
	output logic [tau_pkg::ID_BW-1:0]         o_done_id,
	// Readback
	input  logic [LBW-tau_pkg::CV_BW-1:0]     i_rd_addr,
	output tau_pkg::vector_t                  o_rd_data
);
	import tau_pkg::*;

	// Vector writes between collector and memory
	logic wr_dval;
	wr_t wr;

	sram_write_collector #(
		.LBW(LBW)
	) collector_i (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_alloc_rdy   (i_alloc_rdy),
		.o_alloc_ack   (o_alloc_ack),
		.i_linear      (i_linear),
		.i_size        (i_size),
		.i_alloc       (i_alloc),
		.i_cmd_rdy     (i_cmd_rdy),
		.o_cmd_ack     (o_cmd_ack),
		.i_cmd         (i_cmd),
		.i_dramrd_rdy  (i_dramrd_rdy),
		.o_dramrd_ack  (o_dramrd_ack),
		.i_dramrd      (i_dramrd),
		.o_done_rdy    (o_done_rdy),
		.i_done_ack    (i_done_ack),
		.o_done_linear (o_done_linear),
		.o_done_id     (o_done_id),
		.o_wr_dval     (wr_dval),
		.o_wr          (wr)
	);

	vector_sram #(
		.LBW(LBW)
	) sram_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_wr_dval (wr_dval),
		.i_wr      (wr),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data)
	);

endmodule

// ==== source/vector_sram.sv ====
// Local vector memory
// One full-vector write port and one registered read port
module vector_sram #(
	parameter int LBW = 8
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	// Write port from the collector
	input  logic                              i_wr_dval,
	input  tau_pkg::wr_t                      i_wr,
	// Read port
	input  logic [LBW-tau_pkg::CV_BW-1:0]     i_rd_addr,
	output tau_pkg::vector_t                  o_rd_data
);
	import tau_pkg::*;

	localparam int VBW = LBW - CV_BW;
	localparam int DEPTH = 1 << VBW;

	vector_t mem [DEPTH];
	logic [VBW-1:0] wr_addr;

	// ====================
	// Write
	// ====================
	// Single bank so the id field selects nothing here
	assign wr_addr = i_wr.hiaddr[VBW-1:0];

	always_ff @(posedge i_clk) begin
		if (i_wr_dval) begin
			mem[wr_addr] <= i_wr.data;
		end
	end

	// ====================
	// Read
	// ====================
	// One cycle from address to data
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_rd_data <= '0;
		end else begin
			o_rd_data <= mem[i_rd_addr];
		end
	end

endmodule

// ==== source/sram_write_collector.sv ====
// Write collector FSM and lane shifter
// Packs command runs from DRAM lines into full vector writes
module sram_write_collector #(
	parameter int LBW = 8
) (
	input  logic                         i_clk,
	input  logic                         i_rst,
	// Region allocation
	input  logic                         i_alloc_rdy,
	output logic                         o_alloc_ack,
	input  logic [LBW-1:0]               i_linear,
	input  logic [LBW:0]                 i_size,
	input  tau_pkg::alloc_t              i_alloc,
	// Fill commands
	input  logic                         i_cmd_rdy,
	output logic                         o_cmd_ack,
	input  tau_pkg::cmd_t                i_cmd,
	// DRAM line data
	input  logic                         i_dramrd_rdy,
	output logic                         o_dramrd_ack,
	input  tau_pkg::line_t               i_dramrd,
	// Region finished
	output logic                         o_done_rdy,
	input  logic                         i_done_ack,
	output logic [LBW-1:0]               o_done_linear,
	output logic [tau_pkg::ID_BW-1:0]    o_done_id,
	// Vector write port
	output logic                         o_wr_dval,
	output tau_pkg::wr_t                 o_wr
);
	import tau_pkg::*;

	// ====================
	// Declarations
	// ====================
	localparam int FREE = 0;
	localparam int RUN = 1;
	localparam int COMMIT = 2;
	localparam int VBW = LBW - CV_BW;
	localparam int FBW = LBW + 1;

	logic [2:0] fsm_r;
	logic [2:0] fsm_w;

	// Job fields latched at alloc
	logic [LBW-1:0] linear_r;
	logic [ID_BW-1:0] id_r;
	logic [DBW-1:0] padv_r;
	logic [LBW:0] size_r;

	// Progress counters
	logic [LBW-1:0] cur_r;
	logic [LEN_BW-1:0] handled_r;
	logic [LBW:0] filled_r;
	logic [LBW:0] filled_nxt;

	logic [CV_BW-1:0] lane;
	logic [LEN_BW-1:0] buf_left;
	logic [LEN_BW-1:0] cmd_left;
	logic [LEN_BW-1:0] adv;
	logic cmd_done;
	logic vec_full;
	logic fill_done;
	logic need_line;
	logic step;

	// Datapath
	logic [CC_BW:0] rd_ofs;
	line_t line_shr;
	vector_t line_shl;
	vector_t lane_data;
	logic [VSIZE-1:0] lane_mask;
	vector_t vec_r;
	logic [VBW-1:0] hiaddr_r;

	// ====================
	// Step control
	// ====================
	assign lane = cur_r[CV_BW-1:0];

	always_comb begin
		buf_left = LEN_BW'(VSIZE) - LEN_BW'(lane);
		cmd_left = i_cmd.len - handled_r;
		// Command ends in this step when it fits in the open vector
		cmd_done = cmd_left <= buf_left;
		vec_full = cmd_left >= buf_left;
		adv = cmd_done ? cmd_left : buf_left;
		// Pad runs skip the line unless they close it
		need_line = i_cmd.islast || (i_cmd.ctype != CMD_PAD);
		step = fsm_r[RUN] && i_cmd_rdy && (!need_line || i_dramrd_rdy);
		filled_nxt = filled_r + FBW'(adv);
		fill_done = filled_nxt == size_r;
	end

	assign o_cmd_ack = step && cmd_done;
	assign o_dramrd_ack = step && cmd_done && i_cmd.islast;

	assign o_done_rdy = fsm_r[COMMIT];
	assign o_done_linear = linear_r;
	assign o_done_id = id_r;

	// One-hot next state
	always_comb begin
		fsm_w = '0;
		o_alloc_ack = 1'b0;
		case (1'b1)
			fsm_r[FREE]: begin
				if (i_alloc_rdy) begin
					o_alloc_ack = 1'b1;
					fsm_w[RUN] = 1'b1;
				end else begin
					fsm_w[FREE] = 1'b1;
				end
			end
			fsm_r[RUN]: begin
				if (step && fill_done) begin
					fsm_w[COMMIT] = 1'b1;
				end else begin
					fsm_w[RUN] = 1'b1;
				end
			end
			fsm_r[COMMIT]: begin
				if (i_done_ack) begin
					fsm_w[FREE] = 1'b1;
				end else begin
					fsm_w[COMMIT] = 1'b1;
				end
			end
			default: begin
				fsm_w[FREE] = 1'b1;
			end
		endcase
	end

	// ====================
	// Lane shifter
	// ====================
	always_comb begin
		lane_mask = ~({VSIZE{1'b1}} << adv);
		lane_mask = lane_mask << lane;
		rd_ofs = {1'b0, i_cmd.addrofs} + {1'b0, handled_r[CC_BW-1:0]};
		// First unused word of the run lands in word 0
		line_shr = i_dramrd >> (rd_ofs * DBW);
		// Line and vector are the same width here
		line_shl = vector_t'(line_shr) << (lane * DBW);
		case (i_cmd.ctype)
			CMD_COPY: begin
				lane_data = line_shl;
			end
			CMD_BCAST: begin
				// Same source word for the whole run
				for (int i = 0; i < VSIZE; i++) begin
					lane_data[i] = i_dramrd[i_cmd.addrofs];
				end
			end
			default: begin
				for (int i = 0; i < VSIZE; i++) begin
					lane_data[i] = padv_r;
				end
			end
		endcase
	end

	// ====================
	// Registers
	// ====================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			fsm_r <= 3'(1) << FREE;
			cur_r <= '0;
			handled_r <= '0;
			filled_r <= '0;
			o_wr_dval <= 1'b0;
		end else begin
			fsm_r <= fsm_w;
			// Vector completed in this step goes out next cycle
			o_wr_dval <= step && vec_full;
			if (o_alloc_ack) begin
				cur_r <= i_linear;
				handled_r <= '0;
				filled_r <= '0;
			end else if (step) begin
				cur_r <= cur_r + LBW'(adv);
				handled_r <= cmd_done ? '0 : handled_r + adv;
				filled_r <= filled_nxt;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_alloc_ack) begin
			linear_r <= i_linear;
			id_r <= i_alloc.id;
			padv_r <= i_alloc.padv;
			size_r <= i_size;
		end
		if (step) begin
			hiaddr_r <= cur_r[LBW-1:CV_BW];
		end
	end

	always_ff @(posedge i_clk) begin
		if (step) begin
			for (int i = 0; i < VSIZE; i++) begin
				if (lane_mask[i]) begin
					vec_r[i] <= lane_data[i];
				end
			end
		end
	end

	always_comb begin
		o_wr.id = id_r;
		o_wr.hiaddr = HI_BW'(hiaddr_r);
		o_wr.data = vec_r;
	end

endmodule

// ==== source/tau_pkg.sv ====
// Shared widths, command codes and channel structs for the linear fill path
package tau_pkg;

	// ====================
	// Widths
	// ====================
	localparam int DBW = 16;
	localparam int VSIZE = 8;
	localparam int CSIZE = 8;
	localparam int ID_BW = 2;

	localparam int CV_BW = $clog2(VSIZE);
	localparam int CC_BW = $clog2(CSIZE);
	localparam int LEN_BW = $clog2(VSIZE + 1);

	// Largest local address width a top level may choose
	localparam int MAX_LBW = 12;
	localparam int HI_BW = MAX_LBW - CV_BW;

	typedef logic [VSIZE-1:0][DBW-1:0] vector_t;
	typedef logic [CSIZE-1:0][DBW-1:0] line_t;

	// ====================
	// Commands
	// ====================
	localparam logic [1:0] CMD_COPY = 2'd0;
	localparam logic [1:0] CMD_BCAST = 2'd1;
	localparam logic [1:0] CMD_PAD = 2'd2;

	typedef struct packed {
		logic [1:0] ctype;
		logic islast;
		logic [CC_BW-1:0] addrofs;
		logic [LEN_BW-1:0] len;
	} cmd_t;

	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [DBW-1:0] padv;
	} alloc_t;

	// One full vector write toward the local SRAM
	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [HI_BW-1:0] hiaddr;
		vector_t data;
	} wr_t;

endpackage
